//--- sim.f
+incdir+rtl
rtl/camera_pkg.sv
rtl/bayer_pattern_gen.sv
rtl/pixel_fifo.sv
rtl/pixel_pair_packer.sv
rtl/camera_test_source.sv
bench/clock_gen.sv
bench/camera_test_source_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the camera test source simulation with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=camera_test_source_tb
log=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module "$top" \
    --Mdir obj_dir -o "V$top"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi

//--- bench/camera_test_source_tb.sv
// Camera test source testbench
`timescale 1ns/1ps
`include "camera_macros.svh"

module camera_test_source_tb;

    localparam int hpix        = 16;
    localparam int vpix        = 4;
    localparam int pw          = `CAM_PIX_W;
    localparam int frame_words = hpix * vpix / 2;  // two pixels per word
    localparam int line_words  = hpix / 2;
    // five frames in all over tests 2 to 5
    localparam int total_pix      = 5 * hpix * vpix;
    localparam int timeout_cycles = 4 * total_pix + 500;

    logic                 clk;
    logic                 reset_n;
    logic                 enable;
    camera_pkg::pattern_t pattern;
    logic                 out_valid;
    logic [2*pw-1:0]      out_data;
    logic                 out_sof;
    logic                 out_eol;
    logic                 out_ready;

    logic [2*pw-1:0] got_data [$];    // accepted words
    logic            got_sof [$];
    logic            got_eol [$];
    logic [16:0]     lfsr_q;          // ready source
    int              cycle_count = 0;

    clock_gen #(
        .period      (8),
        .reset_cycles(16)
    ) u_clk (
        .clk    (clk),
        .reset_n(reset_n)
    );

    camera_test_source #(
        .hpix(hpix),
        .vpix(vpix)
    ) uut (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable   (enable),
        .pattern  (pattern),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_sof  (out_sof),
        .out_eol  (out_eol),
        .out_ready(out_ready)
    );

    // maximal length taps x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_rand_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);  // one step per bit
        b      = lfsr_q[0];
    endtask

    // expected raw value at one frame position
    function automatic logic [pw-1:0] ref_pixel(input camera_pkg::pattern_t pat,
                                                 input int x, input int y);
        int   bar;
        int   site;  // 0 blue, 1 green even row, 2 green odd row, 3 red
        logic lit;
        if (pat == camera_pkg::pattern_ramp) begin
            return pw'((x + 4 * y) % 1024);
        end
        bar  = x / (hpix / 4);
        site = 2 * (y % 2) + (x % 2);
        case (bar)
            0:       lit = 1'b1;                         // white
            1:       lit = (site == 0) || (site == 3);   // magenta
            2:       lit = (site == 1) || (site == 2);   // green
            default: lit = (site == 2) || (site == 3);   // red and odd-row green
        endcase
        return lit ? {pw{1'b1}} : '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // run frames and gather every accepted word
    task automatic collect_words(input camera_pkg::pattern_t pat, input int n_words,
                                 input int drop_at, input bit rnd_ready);
        logic r;
        got_data.delete();
        got_sof.delete();
        got_eol.delete();
        pattern   = pat;
        enable    = 1'b1;
        out_ready = 1'b1;
        while (got_data.size() < n_words) begin
            @(posedge clk);
            #1;
            if (got_data.size() >= drop_at) begin
                enable = 1'b0;  // current frame still finishes
            end
            if (rnd_ready) begin
                take_rand_bit(r);
            end else begin
                r = 1'b1;
            end
            out_ready = r;
            if (out_valid && out_ready) begin  // taken at next edge
                got_data.push_back(out_data);
                got_sof.push_back(out_sof);
                got_eol.push_back(out_eol);
            end
        end
        out_ready = 1'b1;
    endtask

    // compare gathered words against the pattern rules
    task automatic check_frames(input camera_pkg::pattern_t pat);
        int              w;
        int              ln;
        int              px;
        logic [2*pw-1:0] exp;
        for (int k = 0; k < got_data.size(); k++) begin
            w   = k % frame_words;
            ln  = w / line_words;
            px  = 2 * (w % line_words);  // first pixel of pair
            exp = {ref_pixel(pat, px + 1, ln), ref_pixel(pat, px, ln)};
            check_value("out_data", 32'(exp), 32'(got_data[k]));
            check_value("out_sof", 32'(w == 0), 32'(got_sof[k]));
            check_value("out_eol", 32'(w % line_words == line_words - 1), 32'(got_eol[k]));
        end
    endtask

    task automatic expect_quiet(input int n_cycles);
        repeat (n_cycles) begin
            @(posedge clk);
            #1;
            check_value("out_valid", 32'h0, 32'(out_valid));
        end
    endtask

    task automatic test_reset_idle();
        repeat (16) begin  // through reset
            @(posedge clk);
            #1;
            check_value("out_valid", 32'h0, 32'(out_valid));
        end
        wait (reset_n === 1'b1);
        expect_quiet(10);  // enable still low
    endtask

    task automatic test_bars_frame();
        collect_words(camera_pkg::pattern_bars, frame_words, 0, 1'b0);
        check_frames(camera_pkg::pattern_bars);
        expect_quiet(20);  // single frame only
    endtask

    task automatic test_ramp_frame();
        collect_words(camera_pkg::pattern_ramp, frame_words, 0, 1'b0);
        check_frames(camera_pkg::pattern_ramp);
        expect_quiet(20);
    endtask

    // bars again with random ready from the LFSR
    task automatic test_bars_backpressure();
        collect_words(camera_pkg::pattern_bars, frame_words, 0, 1'b1);
        check_frames(camera_pkg::pattern_bars);
        expect_quiet(20);
    endtask

    // two chained frames with enable dropped partway through the second
    task automatic test_flags_and_stop();
        collect_words(camera_pkg::pattern_ramp, 2 * frame_words, frame_words + 8, 1'b0);
        check_frames(camera_pkg::pattern_ramp);
        expect_quiet(200);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        enable    = 1'b0;
        pattern   = camera_pkg::pattern_bars;
        out_ready = 1'b0;
        lfsr_q    = 17'd83036;

        test_reset_idle();
        test_bars_frame();
        test_ramp_frame();
        test_bars_backpressure();
        test_flags_and_stop();

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- bench/clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module clock_gen #(
    parameter int period       = 8,   // ns
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset held low, released just after a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

//--- rtl/camera_test_source.sv
// Camera test source top
`timescale 1ns/1ps
`include "camera_macros.svh"

module camera_test_source #(
    parameter int hpix = `CAM_HPIX,
    parameter int vpix = `CAM_VPIX
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable,
    input  camera_pkg::pattern_t    pattern,
    output logic                    out_valid,
    output logic [2*`CAM_PIX_W-1:0] out_data,
    output logic                    out_sof,
    output logic                    out_eol,
    input  logic                    out_ready
);

    logic               push;        // generator write strobe
    camera_pkg::pixel_t gen_pix;     // generator pixel
    logic               credit_ret;  // slot freed in buffer
    logic               rd_valid;    // buffer not empty
    camera_pkg::pixel_t rd_pix;      // buffer head
    logic               pop;         // packer takes head

    // pattern source, paced by buffer credits
    bayer_pattern_gen #(
        .hpix(hpix),
        .vpix(vpix)
    ) u_gen (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable    (enable),
        .pattern   (pattern),
        .credit_ret(credit_ret),
        .push      (push),
        .pix       (gen_pix)
    );

    pixel_fifo #(
        .depth(`CAM_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (push),
        .wr_pix    (gen_pix),
        .pop       (pop),
        .rd_valid  (rd_valid),
        .rd_pix    (rd_pix),
        .credit_ret(credit_ret)
    );

    // two pixels per output word
    pixel_pair_packer u_pack (
        .clk      (clk),
        .reset_n  (reset_n),
        .rd_valid (rd_valid),
        .rd_pix   (rd_pix),
        .pop      (pop),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_sof  (out_sof),
        .out_eol  (out_eol),
        .out_ready(out_ready)
    );

endmodule

//--- rtl/pixel_pair_packer.sv
// Pixel pair packer
`timescale 1ns/1ps
`include "camera_macros.svh"

module pixel_pair_packer (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      rd_valid,
    input  camera_pkg::pixel_t        rd_pix,
    output logic                      pop,
    output logic                      out_valid,
    output logic [2*`CAM_PIX_W-1:0]   out_data,
    output logic                      out_sof,
    output logic                      out_eol,
    input  logic                      out_ready
);

    logic               half;     // first pixel of pair held
    logic               take;     // output slot free this cycle
    camera_pkg::pixel_t first_q;  // first pixel of pair

    // slot empty, or draining right now
    assign take = !out_valid || out_ready;
    assign pop  = rd_valid && take;

    // control
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            half      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;  // word accepted
            end
            if (pop) begin
                half <= !half;
                if (half) begin
                    out_valid <= 1'b1;  // pair complete
                end
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (pop) begin
            if (!half) begin
                first_q <= rd_pix;
            end else begin
                out_data <= {rd_pix.data, first_q.data};  // first pixel low
                out_sof  <= first_q.sof;
                out_eol  <= rd_pix.eol;
            end
        end
    end

endmodule

//--- rtl/pixel_fifo.sv
// Pixel buffer with credit return
`timescale 1ns/1ps
`include "camera_macros.svh"

module pixel_fifo #(
    parameter int depth = `CAM_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               push,
    input  camera_pkg::pixel_t wr_pix,
    input  logic               pop,
    output logic               rd_valid,
    output camera_pkg::pixel_t rd_pix,
    output logic               credit_ret
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    camera_pkg::pixel_t mem [depth];  // storage
    logic [aw-1:0]      wr_ptr;
    logic [aw-1:0]      rd_ptr;
    logic [cw-1:0]      count;       // entries held

    // head shown straight from storage
    assign rd_valid = (count != '0);
    assign rd_pix   = mem[rd_ptr];

    // pointers, occupancy and credit pulse
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;  // one credit back per pop, next cycle

            if (push) begin
                if (wr_ptr == aw'(depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (pop) begin
                if (rd_ptr == aw'(depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            // no full check, producer credits rule out overflow
            count <= count + cw'(push) - cw'(pop);
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_pix;
        end
    end

endmodule

//--- rtl/bayer_pattern_gen.sv
// Bayer test pattern generator
`timescale 1ns/1ps
`include "camera_macros.svh"

module bayer_pattern_gen #(
    parameter int hpix = `CAM_HPIX,
    parameter int vpix = `CAM_VPIX
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 enable,
    input  camera_pkg::pattern_t pattern,
    input  logic                 credit_ret,
    output logic                 push,
    output camera_pkg::pixel_t   pix
);

    localparam int xw    = $clog2(hpix + 1);
    localparam int yw    = $clog2(vpix + 1);
    localparam int cw    = $clog2(`CAM_FIFO_DEPTH + 1);
    localparam int pw    = `CAM_PIX_W;
    localparam int bar_w = hpix / 4;  // pixels per colour bar

    logic [xw-1:0]        x;         // column
    logic [yw-1:0]        y;         // row
    logic                 busy;      // frame in progress
    logic [cw-1:0]        credits;   // free buffer slots
    camera_pkg::pattern_t pat_q;     // pattern for this frame
    logic                 go;
    logic                 last_x;
    logic                 last_pix;
    logic [1:0]           bar;
    logic [3:0]           mask;
    logic [pw-1:0]        bar_val;
    logic [pw-1:0]        ramp_val;

    // issue a pixel only when a slot is guaranteed
    assign go       = busy && (credits != '0);
    assign last_x   = (x == xw'(hpix - 1));
    assign last_pix = last_x && (y == yw'(vpix - 1));

    // bar index, x / bar_w done by compare
    always_comb begin
        if (x >= xw'(3 * bar_w)) begin
            bar = 2'd3;
        end else if (x >= xw'(2 * bar_w)) begin
            bar = 2'd2;
        end else if (x >= xw'(bar_w)) begin
            bar = 2'd1;
        end else begin
            bar = 2'd0;
        end
    end

    assign mask     = camera_pkg::bar_mask[bar];
    assign bar_val  = mask[{y[0], x[0]}] ? '1 : '0;  // site lit or dark
    assign ramp_val = pw'(x) + (pw'(y) << 2);       // wraps at 1024

    // control: frame walk and credit pool
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            x       <= '0;
            y       <= '0;
            credits <= cw'(`CAM_FIFO_DEPTH);  // buffer starts empty
            push    <= 1'b0;
            pat_q   <= camera_pkg::pattern_bars;
        end else begin
            push    <= go;
            credits <= credits - cw'(go) + cw'(credit_ret);  // spend and refund

            if (!busy) begin
                if (enable) begin  // new frame
                    busy  <= 1'b1;
                    x     <= '0;
                    y     <= '0;
                    pat_q <= pattern;
                end
            end else if (go) begin
                if (!last_x) begin
                    x <= x + 1'b1;
                end else begin
                    x <= '0;
                    if (!last_pix) begin
                        y <= y + 1'b1;
                    end else begin
                        // frame done, chain the next one if still enabled
                        y     <= '0;
                        busy  <= enable;
                        pat_q <= pattern;
                    end
                end
            end
        end
    end

    // pixel payload, loaded with each push
    always_ff @(posedge clk) begin
        if (go) begin
            pix.data <= (pat_q == camera_pkg::pattern_ramp) ? ramp_val : bar_val;
            pix.sof  <= (x == '0) && (y == '0);
            pix.eol  <= last_x;
        end
    end

endmodule

//--- rtl/camera_pkg.sv
// Camera test source types
`include "camera_macros.svh"

package camera_pkg;

    // one raw bayer sample plus frame markers
    typedef struct packed {
        logic [`CAM_PIX_W-1:0] data;  // raw sensor value
        logic                  sof;   // first pixel of frame
        logic                  eol;   // last pixel of line
    } pixel_t;

    // test pattern select
    typedef enum logic {
        pattern_bars = 1'b0,  // four vertical colour bars
        pattern_ramp = 1'b1   // x + 4*y diagonal ramp
    } pattern_t;

    // per-bar bayer site masks, bit index is {row parity, col parity}
    // bit 0 blue, bit 1 green on even row, bit 2 green on odd row, bit 3 red
    // element 0 is the leftmost bar
    localparam logic [3:0][3:0] bar_mask = {
        4'b1100,  // red + odd-row green
        4'b0110,  // green only
        4'b1001,  // magenta, red + blue
        4'b1111   // white
    };

endpackage

//--- rtl/camera_macros.svh
// Camera test source defaults
`ifndef CAMERA_MACROS_SVH
`define CAMERA_MACROS_SVH

// default line width in pixels
// keep a multiple of 4 so bars split evenly
`define CAM_HPIX 640

// default frame height in lines
`define CAM_VPIX 400

// pixel buffer entries, also the generator credit pool
`define CAM_FIFO_DEPTH 8

// raw pixel width
`define CAM_PIX_W 10

`endif
